// ==== Bender.yml ====
package:
  name: cpu16

export_include_dirs:
  - include

sources:
  - verilog/cpu16_pkg.sv
  - verilog/imem_apb.sv
  - verilog/pc_manager.sv
  - verilog/register_file.sv
  - verilog/decode_stage.sv
  - verilog/execute_stage.sv
  - verilog/memory_stage.sv
  - verilog/cpu16_top.sv
  - target: test
    files:
      - bench/tb_cpu16.sv

// ==== bench/tb_cpu16.sv ====
`include "cpu16_config.svh"

module tb_cpu16;

  import cpu16_pkg::*;

  localparam int AW = `CPU16_APB_AW;
  localparam int X  = `CPU16_XLEN;

  logic          clk;
  logic          rst;
  logic          psel;
  logic          penable;
  logic          pwrite;
  logic [AW-1:0] paddr;
  logic [X-1:0]  pwdata;
  logic          pready;
  logic [X-1:0]  prdata;
  logic          pslverr;
  logic          wb_valid;
  logic [3:0]    wb_addr;
  logic [X-1:0]  wb_data;
  logic          halted;

  int            n_checks;
  int            n_errors;
  logic [X-1:0]  prog[$];
  logic [3:0]    exp_addr[$];
  logic [X-1:0]  exp_data[$];
  logic [3:0]    got_addr[$];
  logic [X-1:0]  got_data[$];
  time           got_time[$];
  // architectural state as the program should leave it
  logic [X-1:0]  model_r[16];
  logic [X-1:0]  model_mem[int];

  cpu16_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // instruction encoding and the ISA model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [X-1:0] enc_r(opcode_e op, logic [3:0] rd, logic [3:0] rs,
                                         logic [3:0] imm4);
    return {op, rd, rs, imm4};
  endfunction

  function automatic logic [X-1:0] enc_i(opcode_e op, logic [3:0] rd, logic [7:0] imm8);
    return {op, rd, imm8};
  endfunction

  task automatic want_write(input logic [3:0] a, input logic [X-1:0] d);
    exp_addr.push_back(a);
    exp_data.push_back(d);
  endtask

  // a word that must never execute
  // r9 in the trace means it ran
  task automatic skip_word();
    prog.push_back(enc_i(OP_MOVI, 4'd9, 8'hee));
  endtask

  task automatic begin_program();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    for (int i = 0; i < 16; i++) begin
      model_r[i] = '0;
    end
  endtask

  // appends one instruction and the register write it should produce
  task automatic do_op(input opcode_e op, input logic [3:0] rd, input logic [3:0] rs,
                       input logic [7:0] imm);
    logic [X-1:0] x;
    logic [X-1:0] y;
    logic [X-1:0] res;
    logic [3:0]   s;
    logic         writes;
    int           addr;
    x      = model_r[rd];
    y      = model_r[rs];
    s      = imm[3:0];
    addr   = (y + s) & (`CPU16_DMEM_DEPTH - 1);
    res    = '0;
    writes = 1'b1;
    case (op)
      OP_ADD:  res = x + y;
      OP_SUB:  res = x - y;
      OP_AND:  res = x & y;
      OP_ORR:  res = x | y;
      OP_XOR:  res = x ^ y;
      OP_MOVI: res = {8'h00, imm};
      OP_ADDI: res = x + {8'h00, imm};
      OP_LSL:  res = y << s;
      OP_LSR:  res = y >> s;
      // vacated top bits take a copy of bit 15
      OP_ASR:  res = (y >> s) | (y[X-1] ? ~(16'hffff >> s) : 16'h0000);
      OP_LDR:  res = model_mem[addr];
      OP_STR: begin
        model_mem[addr] = x;
        writes          = 1'b0;
      end
      default: writes = 1'b0;
    endcase
    if (op inside {OP_MOVI, OP_ADDI, OP_BCC}) begin
      prog.push_back(enc_i(op, rd, imm));
    end else begin
      prog.push_back(enc_r(op, rd, rs, s));
    end
    if (writes) begin
      model_r[rd] = res;
      want_write(rd, res);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // APB, trace capture and compare
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_val(input string sig, input time t, input logic [X-1:0] got,
                           input logic [X-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAIL t=%0t %s got %h exp %h", t, sig, got, exp);
    end
  endtask

  task automatic apb_xfer(input logic wr, input logic [AW-1:0] addr, input logic [X-1:0] wdata,
                          output logic [X-1:0] rdata, output logic err);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    // access phase lasts one cycle without wait states
    @(negedge clk);
    check_val("pready", $time, {15'd0, pready}, 16'd1);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic sample_trace();
    @(negedge clk);
    if (wb_valid) begin
      got_addr.push_back(wb_addr);
      got_data.push_back(wb_data);
      got_time.push_back($time);
    end
  endtask

  task automatic run_program(input string name);
    logic [X-1:0]  rdata;
    logic          err;
    logic [AW-1:0] addr;
    int            cycles;
    got_addr.delete();
    got_data.delete();
    got_time.delete();
    @(posedge clk);
    #1;
    rst = 1'b1;
    repeat (4) @(posedge clk);
    foreach (prog[i]) begin
      addr = 2 * i;
      apb_xfer(1'b1, addr, prog[i], rdata, err);
    end
    @(posedge clk);
    #1;
    rst    = 1'b0;
    cycles = 0;
    while (!halted && cycles < 2000) begin
      sample_trace();
      cycles++;
    end
    if (!halted) begin
      n_errors++;
      $display("ERROR t=%0t %s timed out before halted rose", $time, name);
    end
    // older instructions drain within three cycles
    // nothing may write after that
    repeat (8) sample_trace();
    n_checks++;
    if (got_addr.size() != exp_addr.size()) begin
      n_errors++;
      $display("ERROR %s saw %0d register writes, expected %0d", name, got_addr.size(),
               exp_addr.size());
    end
    for (int i = 0; i < got_addr.size() && i < exp_addr.size(); i++) begin
      check_val({name, " wb_addr"}, got_time[i], got_addr[i], exp_addr[i]);
      check_val({name, " wb_data"}, got_time[i], got_data[i], exp_data[i]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic alu_chains();
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    logic [7:0] d;
    for (int round = 0; round < 2; round++) begin
      a = 8'($urandom);
      b = 8'($urandom);
      c = 8'($urandom);
      d = 8'($urandom);
      begin_program();
      do_op(OP_MOVI, 1, 0, a);
      do_op(OP_MOVI, 2, 0, b);
      do_op(OP_MOVI, 3, 0, c);
      // operands from one, two and three words back
      do_op(OP_ADD, 1, 2, 0);
      do_op(OP_SUB, 2, 1, 0);
      do_op(OP_AND, 3, 1, 0);
      // r1 from three back goes through the register file bypass
      do_op(OP_ORR, 1, 3, 0);
      do_op(OP_XOR, 2, 1, 0);
      do_op(OP_ADDI, 3, 0, d);
      do_op(OP_ADD, 4, 3, 0);
      do_op(OP_SUB, 1, 2, 0);
      do_op(OP_XOR, 4, 4, 0);
      do_op(OP_HLT, 0, 0, 0);
      run_program("alu_chains");
    end
  endtask

  task automatic shift_ops();
    logic [7:0] v;
    logic [7:0] w;
    v = 8'($urandom) | 8'h80;
    w = 8'($urandom);
    begin_program();
    do_op(OP_MOVI, 5, 0, v);
    do_op(OP_LSL, 6, 5, 8);
    do_op(OP_ADDI, 6, 0, w);
    do_op(OP_LSL, 7, 6, 0);
    do_op(OP_LSL, 8, 6, 15);
    do_op(OP_LSR, 9, 6, 4);
    do_op(OP_LSR, 10, 6, 15);
    // r6 is negative here
    do_op(OP_ASR, 11, 6, 3);
    do_op(OP_ASR, 12, 6, 15);
    do_op(OP_ASR, 13, 6, 0);
    do_op(OP_ASR, 14, 5, 2);
    do_op(OP_HLT, 0, 0, 0);
    run_program("shifts");
  endtask

  task automatic load_store_pair();
    logic [7:0] base;
    logic [7:0] v;
    logic [7:0] w;
    logic [7:0] x;
    base = 8'($urandom) & 8'hf0;
    v    = 8'($urandom);
    w    = 8'($urandom);
    x    = 8'($urandom);
    begin_program();
    do_op(OP_MOVI, 1, 0, base);
    do_op(OP_MOVI, 2, 0, v);
    do_op(OP_LSL, 2, 2, 8);
    do_op(OP_ADDI, 2, 0, w);
    do_op(OP_STR, 2, 1, 3);
    do_op(OP_STR, 1, 1, 4);
    do_op(OP_LDR, 3, 1, 3);
    do_op(OP_MOVI, 5, 0, x);
    // loaded r3 at distance two
    do_op(OP_ADD, 5, 3, 0);
    do_op(OP_LDR, 6, 1, 4);
    do_op(OP_MOVI, 7, 0, 8'h01);
    do_op(OP_XOR, 7, 6, 0);
    do_op(OP_HLT, 0, 0, 0);
    run_program("load_store");
  endtask

  task automatic branch_flow();
    logic [7:0] x;
    logic [7:0] y;
    x = 8'($urandom) | 8'h80;
    y = 8'($urandom) & 8'h3f;
    begin_program();
    do_op(OP_MOVI, 1, 0, x);
    do_op(OP_MOVI, 2, 0, x);
    do_op(OP_CMP, 1, 2, 0);
    // word 3 branches to word 6
    do_op(OP_BCC, COND_EQ, 0, 8'd3);
    do_op(OP_MOVI, 3, 0, 8'h11);
    skip_word();
    do_op(OP_BCC, COND_NE, 0, 8'd3);
    do_op(OP_MOVI, 4, 0, 8'h22);
    do_op(OP_MOVI, 5, 0, 8'h33);
    do_op(OP_MOVI, 6, 0, y);
    // LT holds since y is below x
    do_op(OP_CMP, 6, 1, 0);
    do_op(OP_BCC, COND_GE, 0, 8'd4);
    do_op(OP_MOVI, 7, 0, 8'h44);
    do_op(OP_BCC, COND_LT, 0, 8'd3);
    do_op(OP_MOVI, 8, 0, 8'h55);
    skip_word();
    // word 16
    do_op(OP_CMP, 1, 6, 0);
    do_op(OP_BCC, COND_GE, 0, 8'd3);
    do_op(OP_ADDI, 8, 0, 8'd1);
    skip_word();
    do_op(OP_BCC, COND_NE, 0, 8'd3);
    do_op(OP_ADDI, 8, 0, 8'd1);
    skip_word();
    do_op(OP_BCC, COND_EQ, 0, 8'd3);
    do_op(OP_MOVI, 14, 0, 8'h66);
    do_op(OP_MOVI, 10, 0, 8'd0);
    do_op(OP_MOVI, 11, 0, 8'd3);
    // loop at word 27 exits when r10 reaches r11
    prog.push_back(enc_i(OP_ADDI, 4'd10, 8'd1));
    prog.push_back(enc_r(OP_CMP, 4'd10, 4'd11, 4'd0));
    prog.push_back(enc_i(OP_BCC, COND_EQ, 8'd4));
    prog.push_back(enc_i(OP_ADDI, 4'd13, 8'd1));
    prog.push_back(enc_i(OP_BCC, COND_AL, 8'hfc));
    prog.push_back(enc_i(OP_ADDI, 4'd12, 8'd1));
    do_op(OP_HLT, 0, 0, 0);
    skip_word();
    for (int i = 1; i <= 3; i++) begin
      want_write(4'd10, 16'(i));
      want_write(4'd13, 16'(i));
      if (i < 3) begin
        want_write(4'd12, 16'(i));
      end
    end
    run_program("branches");
  endtask

  task automatic apb_readback();
    logic [X-1:0]  rdata;
    logic [X-1:0]  wdata;
    logic [X-1:0]  keep;
    logic [AW-1:0] addr;
    logic          err;
    for (int i = 0; i < 4; i++) begin
      addr  = 2 * ($urandom % `CPU16_IMEM_DEPTH);
      wdata = 16'($urandom);
      apb_xfer(1'b1, addr, wdata, rdata, err);
      check_val("pslverr", $time, {15'd0, err}, 16'd0);
      apb_xfer(1'b0, addr, '0, rdata, err);
      check_val("prdata", $time, rdata, wdata);
      check_val("pslverr", $time, {15'd0, err}, 16'd0);
    end
    // word 255 shares its low index bits with the out of range word 511
    keep = 16'($urandom);
    apb_xfer(1'b1, 10'h1fe, keep, rdata, err);
    apb_xfer(1'b1, 10'h3fe, ~keep, rdata, err);
    check_val("pslverr", $time, {15'd0, err}, 16'd1);
    apb_xfer(1'b0, 10'h3fe, '0, rdata, err);
    check_val("pslverr", $time, {15'd0, err}, 16'd1);
    check_val("prdata", $time, rdata, 16'd0);
    apb_xfer(1'b0, 10'h1fe, '0, rdata, err);
    check_val("prdata", $time, rdata, keep);
  endtask

  initial begin
    rst      = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    n_checks = 0;
    n_errors = 0;
    void'($urandom(32'h3f04));
    repeat (4) @(posedge clk);
    alu_chains();
    shift_ops();
    load_store_pair();
    branch_flow();
    apb_readback();
    $display("checks %0d errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+include
verilog/cpu16_pkg.sv
verilog/imem_apb.sv
verilog/pc_manager.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/cpu16_top.sv
bench/tb_cpu16.sv

// ==== include/cpu16_config.svh ====
`ifndef CPU16_CONFIG_SVH
`define CPU16_CONFIG_SVH

// datapath and instruction word width
`define CPU16_XLEN 16

// architectural registers r0..r15
`define CPU16_NREGS 16

// memory depths in 16-bit words
`define CPU16_IMEM_DEPTH 256
`define CPU16_DMEM_DEPTH 256

// APB byte address, bit 0 not decoded
`define CPU16_APB_AW 10

`endif

// ==== verilog/cpu16_pkg.sv ====
package cpu16_pkg;

  // opcode field, instruction bits 15..12
  typedef enum logic [3:0] {
    OP_NOP  = 4'h0,
    OP_ADD  = 4'h1,
    OP_SUB  = 4'h2,
    OP_AND  = 4'h3,
    OP_ORR  = 4'h4,
    OP_XOR  = 4'h5,
    OP_MOVI = 4'h6,
    OP_ADDI = 4'h7,
    OP_LSL  = 4'h8,
    OP_LSR  = 4'h9,
    OP_ASR  = 4'ha,
    OP_LDR  = 4'hb,
    OP_STR  = 4'hc,
    OP_CMP  = 4'hd,
    OP_BCC  = 4'he,
    OP_HLT  = 4'hf
  } opcode_e;

  // nine operations, so the field needs four bits
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_ORR,
    ALU_XOR,
    ALU_PASS_B,
    ALU_LSL,
    ALU_LSR,
    ALU_ASR
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1
  } wb_sel_e;

  // branch condition, bits 11..8 of BCC
  typedef enum logic [3:0] {
    COND_AL = 4'h0,
    COND_EQ = 4'h1,
    COND_NE = 4'h2,
    COND_LT = 4'h3,
    COND_GE = 4'h4,
    COND_CS = 4'h5,
    COND_CC = 4'h6
  } cond_e;

endpackage

// ==== verilog/cpu16_top.sv ====
`include "cpu16_config.svh"

module cpu16_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [`CPU16_APB_AW-1:0]        paddr,
  input  logic [`CPU16_XLEN-1:0]          pwdata,
  output logic                            pready,
  output logic [`CPU16_XLEN-1:0]          prdata,
  output logic                            pslverr,
  output logic                            wb_valid,
  output logic [$clog2(`CPU16_NREGS)-1:0] wb_addr,
  output logic [`CPU16_XLEN-1:0]          wb_data,
  output logic                            halted
);

  import cpu16_pkg::*;

  localparam int X  = `CPU16_XLEN;
  localparam int RW = $clog2(`CPU16_NREGS);

  // fetch and IF/ID
  logic [X-1:0]  fetch_addr;
  logic [X-1:0]  fetch_instr;
  logic [X-1:0]  ifid_instr;
  logic [X-1:0]  ifid_pc;

  // decode back to fetch
  logic          branch_taken;
  logic [X-1:0]  branch_target;
  logic          hlt_seen;

  // ID/EX
  alu_op_e       idex_alu_op;
  wb_sel_e       idex_wb_sel;
  logic [RW-1:0] idex_rd;
  logic [RW-1:0] idex_rs_addr;
  logic [RW-1:0] idex_rd_addr;
  logic [X-1:0]  idex_a;
  logic [X-1:0]  idex_b;
  logic [X-1:0]  idex_imm;
  logic          idex_use_imm;
  logic          idex_reg_we;
  logic          idex_mem_we;
  logic          idex_set_flags;

  // flags forwarded from execute into decode
  logic [3:0]    ex_flags;

  // EX/MEM
  logic [X-1:0]  ex_mem_result;
  logic [X-1:0]  ex_mem_store_data;
  logic [RW-1:0] ex_mem_rd;
  logic          ex_mem_reg_we;
  logic          ex_mem_mem_we;
  wb_sel_e       ex_mem_wb_sel;

  imem_apb      imem_apb      (.*);
  pc_manager    pc_manager    (.*);
  decode_stage  decode_stage  (.*);
  execute_stage execute_stage (.*);
  memory_stage  memory_stage  (.*);

endmodule

// ==== verilog/decode_stage.sv ====
`include "cpu16_config.svh"

module decode_stage (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [`CPU16_XLEN-1:0]          ifid_instr,
  input  logic [`CPU16_XLEN-1:0]          ifid_pc,
  input  logic [3:0]                      ex_flags,
  input  logic                            wb_valid,
  input  logic [$clog2(`CPU16_NREGS)-1:0] wb_addr,
  input  logic [`CPU16_XLEN-1:0]          wb_data,
  output logic                            branch_taken,
  output logic [`CPU16_XLEN-1:0]          branch_target,
  output logic                            hlt_seen,
  output cpu16_pkg::alu_op_e              idex_alu_op,
  output cpu16_pkg::wb_sel_e              idex_wb_sel,
  output logic [$clog2(`CPU16_NREGS)-1:0] idex_rd,
  output logic [$clog2(`CPU16_NREGS)-1:0] idex_rs_addr,
  output logic [$clog2(`CPU16_NREGS)-1:0] idex_rd_addr,
  output logic [`CPU16_XLEN-1:0]          idex_a,
  output logic [`CPU16_XLEN-1:0]          idex_b,
  output logic [`CPU16_XLEN-1:0]          idex_imm,
  output logic                            idex_use_imm,
  output logic                            idex_reg_we,
  output logic                            idex_mem_we,
  output logic                            idex_set_flags
);

  import cpu16_pkg::*;

  localparam int X  = `CPU16_XLEN;
  localparam int RW = $clog2(`CPU16_NREGS);

  opcode_e       op;
  cond_e         cond;
  logic [RW-1:0] rd_f;
  logic [RW-1:0] rs_f;
  logic [RW-1:0] raddr1;
  logic [RW-1:0] raddr2;
  logic [X-1:0]  rdata1;
  logic [X-1:0]  rdata2;
  logic [X-1:0]  imm;
  logic [X-1:0]  imm8_z;
  logic [X-1:0]  imm4_z;
  alu_op_e       alu_op;
  wb_sel_e       wb_sel;
  logic          use_imm;
  logic          reg_we;
  logic          mem_we;
  logic          set_flags;
  logic          cond_ok;
  logic          flag_n;
  logic          flag_z;
  logic          flag_c;
  logic          flag_v;

  assign op     = opcode_e'(ifid_instr[15:12]);
  assign cond   = cond_e'(ifid_instr[11:8]);
  assign rd_f   = ifid_instr[11:8];
  assign rs_f   = ifid_instr[7:4];
  assign imm8_z = {{(X-8){1'b0}}, ifid_instr[7:0]};
  assign imm4_z = {{(X-4){1'b0}}, ifid_instr[3:0]};

  assign {flag_n, flag_z, flag_c, flag_v} = ex_flags;

  ////////////////////////////////////////////////////////////////////////////
  // branch and halt, resolved here with one delay slot
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (cond)
      COND_AL: cond_ok = 1'b1;
      COND_EQ: cond_ok = flag_z;
      COND_NE: cond_ok = !flag_z;
      COND_LT: cond_ok = (flag_n != flag_v);
      COND_GE: cond_ok = (flag_n == flag_v);
      COND_CS: cond_ok = flag_c;
      COND_CC: cond_ok = !flag_c;
      default: cond_ok = 1'b0;
    endcase
  end

  assign branch_taken  = (op == OP_BCC) && cond_ok;
  assign branch_target = ifid_pc + {{(X-8){ifid_instr[7]}}, ifid_instr[7:0]};
  assign hlt_seen      = (op == OP_HLT);

  ////////////////////////////////////////////////////////////////////////////
  // controls; port 1 feeds operand a, port 2 operand b or store data
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_op    = ALU_ADD;
    wb_sel    = WB_ALU;
    use_imm   = 1'b0;
    reg_we    = 1'b0;
    mem_we    = 1'b0;
    set_flags = 1'b0;
    imm       = imm8_z;
    raddr1    = rd_f;
    raddr2    = rs_f;
    case (op)
      OP_ADD, OP_SUB: begin
        alu_op    = (op == OP_SUB) ? ALU_SUB : ALU_ADD;
        reg_we    = 1'b1;
        set_flags = 1'b1;
      end
      OP_AND, OP_ORR, OP_XOR: begin
        alu_op = (op == OP_AND) ? ALU_AND : (op == OP_ORR) ? ALU_ORR : ALU_XOR;
        reg_we = 1'b1;
      end
      OP_MOVI, OP_ADDI: begin
        alu_op  = (op == OP_MOVI) ? ALU_PASS_B : ALU_ADD;
        use_imm = 1'b1;
        reg_we  = 1'b1;
      end
      OP_LSL, OP_LSR, OP_ASR: begin
        alu_op  = (op == OP_LSL) ? ALU_LSL : (op == OP_LSR) ? ALU_LSR : ALU_ASR;
        raddr1  = rs_f;
        imm     = imm4_z;
        use_imm = 1'b1;
        reg_we  = 1'b1;
      end
      OP_LDR: begin
        raddr1  = rs_f;
        imm     = imm4_z;
        use_imm = 1'b1;
        reg_we  = 1'b1;
        wb_sel  = WB_MEM;
      end
      OP_STR: begin
        raddr1  = rs_f;
        raddr2  = rd_f;
        imm     = imm4_z;
        use_imm = 1'b1;
        mem_we  = 1'b1;
      end
      OP_CMP: begin
        alu_op    = ALU_SUB;
        set_flags = 1'b1;
      end
      // NOP, BCC and HLT leave the datapath idle
      default: ;
    endcase
  end

  register_file register_file (
    .clk    (clk),
    .rst    (rst),
    .we     (wb_valid),
    .waddr  (wb_addr),
    .wdata  (wb_data),
    .raddr1 (raddr1),
    .raddr2 (raddr2),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  // ID/EX
  always_ff @(posedge clk) begin
    if (rst) begin
      idex_reg_we    <= 1'b0;
      idex_mem_we    <= 1'b0;
      idex_set_flags <= 1'b0;
    end else begin
      idex_reg_we    <= reg_we;
      idex_mem_we    <= mem_we;
      idex_set_flags <= set_flags;
    end
  end

  always_ff @(posedge clk) begin
    idex_alu_op  <= alu_op;
    idex_wb_sel  <= wb_sel;
    idex_rd      <= rd_f;
    idex_rd_addr <= raddr1;
    idex_rs_addr <= raddr2;
    idex_a       <= rdata1;
    idex_b       <= rdata2;
    idex_imm     <= imm;
    idex_use_imm <= use_imm;
  end

endmodule

// ==== verilog/execute_stage.sv ====
`include "cpu16_config.svh"

module execute_stage (
  input  logic                            clk,
  input  logic                            rst,
  input  cpu16_pkg::alu_op_e              idex_alu_op,
  input  cpu16_pkg::wb_sel_e              idex_wb_sel,
  input  logic [$clog2(`CPU16_NREGS)-1:0] idex_rd,
  input  logic [$clog2(`CPU16_NREGS)-1:0] idex_rs_addr,
  input  logic [$clog2(`CPU16_NREGS)-1:0] idex_rd_addr,
  input  logic [`CPU16_XLEN-1:0]          idex_a,
  input  logic [`CPU16_XLEN-1:0]          idex_b,
  input  logic [`CPU16_XLEN-1:0]          idex_imm,
  input  logic                            idex_use_imm,
  input  logic                            idex_reg_we,
  input  logic                            idex_mem_we,
  input  logic                            idex_set_flags,
  input  logic                            wb_valid,
  input  logic [$clog2(`CPU16_NREGS)-1:0] wb_addr,
  input  logic [`CPU16_XLEN-1:0]          wb_data,
  output logic [3:0]                      ex_flags,
  output logic [`CPU16_XLEN-1:0]          ex_mem_result,
  output logic [`CPU16_XLEN-1:0]          ex_mem_store_data,
  output logic [$clog2(`CPU16_NREGS)-1:0] ex_mem_rd,
  output logic                            ex_mem_reg_we,
  output logic                            ex_mem_mem_we,
  output cpu16_pkg::wb_sel_e              ex_mem_wb_sel
);

  import cpu16_pkg::*;

  localparam int X = `CPU16_XLEN;

  logic [X-1:0] fwd_a;
  logic [X-1:0] fwd_b;
  logic [X-1:0] op_b;
  logic [X-1:0] b_eff;
  logic [X-1:0] result;
  logic [X:0]   sum;
  logic [3:0]   shamt;
  logic [3:0]   flags_q;
  logic         sub;
  logic         exmem_fwd_ok;

  ////////////////////////////////////////////////////////////////////////////
  // forwarding, EX/MEM before MEM/WB
  ////////////////////////////////////////////////////////////////////////////

  // load data is not ready in EX/MEM yet
  assign exmem_fwd_ok = ex_mem_reg_we && (ex_mem_wb_sel == WB_ALU);

  always_comb begin
    if (exmem_fwd_ok && (ex_mem_rd == idex_rd_addr)) begin
      fwd_a = ex_mem_result;
    end else if (wb_valid && (wb_addr == idex_rd_addr)) begin
      fwd_a = wb_data;
    end else begin
      fwd_a = idex_a;
    end
  end

  always_comb begin
    if (exmem_fwd_ok && (ex_mem_rd == idex_rs_addr)) begin
      fwd_b = ex_mem_result;
    end else if (wb_valid && (wb_addr == idex_rs_addr)) begin
      fwd_b = wb_data;
    end else begin
      fwd_b = idex_b;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // ALU and shifter
  ////////////////////////////////////////////////////////////////////////////

  assign op_b  = idex_use_imm ? idex_imm : fwd_b;
  assign shamt = op_b[3:0];

  // subtract as a + ~b + 1, carry out means no borrow
  assign sub   = (idex_alu_op == ALU_SUB);
  assign b_eff = sub ? ~op_b : op_b;
  assign sum   = {1'b0, fwd_a} + {1'b0, b_eff} + {{X{1'b0}}, sub};

  always_comb begin
    case (idex_alu_op)
      ALU_ADD, ALU_SUB: result = sum[X-1:0];
      ALU_AND:          result = fwd_a & op_b;
      ALU_ORR:          result = fwd_a | op_b;
      ALU_XOR:          result = fwd_a ^ op_b;
      ALU_PASS_B:       result = op_b;
      ALU_LSL:          result = fwd_a << shamt;
      ALU_LSR:          result = fwd_a >> shamt;
      ALU_ASR:          result = $signed(fwd_a) >>> shamt;
      default:          result = '0;
    endcase
  end

  // flags {n, z, c, v}, passed straight to a branch in decode
  assign ex_flags = idex_set_flags ?
                    {sum[X-1], (sum[X-1:0] == '0), sum[X],
                     (fwd_a[X-1] == b_eff[X-1]) && (sum[X-1] != fwd_a[X-1])} :
                    flags_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      flags_q <= '0;
    end else begin
      flags_q <= ex_flags;
    end
  end

  // EX/MEM
  always_ff @(posedge clk) begin
    if (rst) begin
      ex_mem_reg_we <= 1'b0;
      ex_mem_mem_we <= 1'b0;
    end else begin
      ex_mem_reg_we <= idex_reg_we;
      ex_mem_mem_we <= idex_mem_we;
    end
  end

  always_ff @(posedge clk) begin
    ex_mem_result     <= result;
    ex_mem_store_data <= fwd_b;
    ex_mem_rd         <= idex_rd;
    ex_mem_wb_sel     <= idex_wb_sel;
  end

  // STR decodes without a register write
  a_store_not_reg_write: assert property (
    @(posedge clk) disable iff (rst) ex_mem_mem_we |-> !ex_mem_reg_we
  );

endmodule

// ==== verilog/imem_apb.sv ====
`include "cpu16_config.svh"

module imem_apb (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [`CPU16_APB_AW-1:0] paddr,
  input  logic [`CPU16_XLEN-1:0]   pwdata,
  output logic                     pready,
  output logic [`CPU16_XLEN-1:0]   prdata,
  output logic                     pslverr,
  input  logic [`CPU16_XLEN-1:0]   fetch_addr,
  output logic [`CPU16_XLEN-1:0]   fetch_instr
);

  localparam int IW = $clog2(`CPU16_IMEM_DEPTH);

  logic [`CPU16_XLEN-1:0]   mem [`CPU16_IMEM_DEPTH];
  logic [`CPU16_APB_AW-2:0] word_idx;
  logic                     in_range;
  logic                     setup_phase;
  logic                     access_phase;

  assign word_idx     = paddr[`CPU16_APB_AW-1:1];
  assign in_range     = (word_idx < `CPU16_IMEM_DEPTH);
  assign setup_phase  = psel && !penable;
  assign access_phase = psel && penable;

  // asynchronous fetch port
  assign fetch_instr = mem[fetch_addr[IW-1:0]];

  always_ff @(posedge clk) begin
    if (access_phase && pwrite && in_range) begin
      mem[word_idx[IW-1:0]] <= pwdata;
    end
  end

  // no wait states, every access phase completes
  assign pready  = access_phase;
  assign pslverr = access_phase && !in_range;

  // out of range reads return zero
  always_ff @(posedge clk) begin
    if (setup_phase && !pwrite && in_range) begin
      prdata <= mem[word_idx[IW-1:0]];
    end else begin
      prdata <= '0;
    end
  end

  // bus master protocol check
  a_penable_needs_psel: assert property (
    @(posedge clk) disable iff (rst) penable |-> psel
  );

endmodule

// ==== verilog/memory_stage.sv ====
`include "cpu16_config.svh"

module memory_stage (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [`CPU16_XLEN-1:0]          ex_mem_result,
  input  logic [`CPU16_XLEN-1:0]          ex_mem_store_data,
  input  logic [$clog2(`CPU16_NREGS)-1:0] ex_mem_rd,
  input  logic                            ex_mem_reg_we,
  input  logic                            ex_mem_mem_we,
  input  cpu16_pkg::wb_sel_e              ex_mem_wb_sel,
  output logic                            wb_valid,
  output logic [$clog2(`CPU16_NREGS)-1:0] wb_addr,
  output logic [`CPU16_XLEN-1:0]          wb_data
);

  import cpu16_pkg::*;

  localparam int DW = $clog2(`CPU16_DMEM_DEPTH);

  logic [`CPU16_XLEN-1:0] dmem [`CPU16_DMEM_DEPTH];
  logic [`CPU16_XLEN-1:0] load_data;
  logic [DW-1:0]          dmem_idx;

  // address wraps on the low bits
  assign dmem_idx  = ex_mem_result[DW-1:0];
  assign load_data = dmem[dmem_idx];

  always_ff @(posedge clk) begin
    if (ex_mem_mem_we) begin
      dmem[dmem_idx] <= ex_mem_store_data;
    end
  end

  // MEM/WB, also the write-back trace
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= ex_mem_reg_we;
    end
  end

  always_ff @(posedge clk) begin
    wb_addr <= ex_mem_rd;
    wb_data <= (ex_mem_wb_sel == WB_MEM) ? load_data : ex_mem_result;
  end

endmodule

// ==== verilog/pc_manager.sv ====
`include "cpu16_config.svh"

module pc_manager (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`CPU16_XLEN-1:0] fetch_instr,
  input  logic                   branch_taken,
  input  logic [`CPU16_XLEN-1:0] branch_target,
  input  logic                   hlt_seen,
  output logic [`CPU16_XLEN-1:0] fetch_addr,
  output logic [`CPU16_XLEN-1:0] ifid_instr,
  output logic [`CPU16_XLEN-1:0] ifid_pc,
  output logic                   halted
);

  import cpu16_pkg::*;

  localparam int X = `CPU16_XLEN;

  logic [X-1:0] pc;

  assign fetch_addr = pc;

  // word addressed pc, halt freezes it
  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= '0;
      halted <= 1'b0;
    end else if (hlt_seen) begin
      halted <= 1'b1;
    end else if (branch_taken) begin
      pc <= branch_target;
    end else begin
      pc <= pc + 1'b1;
    end
  end

  // IF/ID; the word fetched behind HLT is dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      ifid_instr <= {OP_NOP, {(X-4){1'b0}}};
    end else if (hlt_seen) begin
      ifid_instr <= {OP_HLT, {(X-4){1'b0}}};
    end else begin
      ifid_instr <= fetch_instr;
    end
  end

  always_ff @(posedge clk) begin
    if (!hlt_seen) begin
      ifid_pc <= pc;
    end
  end

  // decode never raises both for the same instruction
  a_branch_xor_halt: assert property (
    @(posedge clk) disable iff (rst) !(branch_taken && hlt_seen)
  );

endmodule

// ==== verilog/register_file.sv ====
`include "cpu16_config.svh"

module register_file (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            we,
  input  logic [$clog2(`CPU16_NREGS)-1:0] waddr,
  input  logic [`CPU16_XLEN-1:0]          wdata,
  input  logic [$clog2(`CPU16_NREGS)-1:0] raddr1,
  input  logic [$clog2(`CPU16_NREGS)-1:0] raddr2,
  output logic [`CPU16_XLEN-1:0]          rdata1,
  output logic [`CPU16_XLEN-1:0]          rdata2
);

  logic [`CPU16_XLEN-1:0] regs [`CPU16_NREGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CPU16_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // write-before-read, covers distance three
  assign rdata1 = (we && (waddr == raddr1)) ? wdata : regs[raddr1];
  assign rdata2 = (we && (waddr == raddr2)) ? wdata : regs[raddr2];

endmodule
